//--- Bender.yml
package:
  name: spec_mem_pager

sources:
  - include_dirs:
      - src
    files:
      - src/spec_pkg.sv
      - src/spec_port_decode.sv
      - src/spec_page_regs.sv
      - src/spec_ram_map.sv
      - src/spec_mem_pager.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_spec_mem_pager.sv

//--- compile.f
+incdir+src
src/spec_pkg.sv
src/spec_port_decode.sv
src/spec_page_regs.sv
src/spec_ram_map.sv
src/spec_mem_pager.sv
tb/tb_spec_mem_pager.sv

//--- src/spec_cfg.svh
`ifndef SPEC_CFG_SVH
`define SPEC_CFG_SVH

// ========================================
// Bus and SDRAM widths
// ========================================

`define SPEC_ADDR_W 16          // Z80 address bus
`define SPEC_RAM_AW 25          // SDRAM byte address

// ROM area sits above the RAM banks
`define SPEC_ROM_BASE 3'b101

// ========================================
// Machine codes on the mode input
// ========================================

`define SPEC_MACH_128    3'd0   // 128K / +2
`define SPEC_MACH_P1024  3'd1   // Pentagon 1024
`define SPEC_MACH_PF1024 3'd2   // Profi 1024
`define SPEC_MACH_48     3'd3
`define SPEC_MACH_PLUS3  3'd4   // +2A / +3

// ========================================
// Fixed RAM banks
// ========================================

// Slot at 4000 always shows the screen bank
`define SPEC_BANK_SCREEN 3'd5
`define SPEC_BANK_MID    3'd2   // slot at 8000

`endif

//--- src/spec_mem_pager.sv
`include "spec_cfg.svh"

module spec_mem_pager (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic [2:0]              machine,
	input  logic [`SPEC_ADDR_W-1:0] addr,
	input  logic [7:0]              data,
	input  logic                    mreq_n,
	input  logic                    iorq_n,
	input  logic                    rd_n,
	input  logic                    wr_n,
	input  logic                    m1_n,
	output logic [`SPEC_RAM_AW-1:0] ram_addr,
	output logic                    ram_rd,
	output logic                    ram_we,
	output logic [2:0]              border_color,
	output logic                    ear_out,
	output logic                    mic_out,
	output logic                    page_scr
);

	import spec_pkg::*;

	machine_t   mach_type;
	logic       io_wr_pulse;
	logic       sel_7ffd;
	logic       sel_7ffd_alias;
	logic       sel_1ffd;
	logic       sel_dffd;
	logic       sel_eff7;
	logic       sel_ula;
	logic       mem_rd;
	logic       mem_wr;
	logic [7:0] page_reg;
	plus3_ctl_u plus3_ctl;
	logic [2:0] page_ext;
	logic       zx48;
	logic       plus3;

	assign mach_type = machine_t'(machine);

	spec_port_decode u_decode (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.addr           (addr),
		.mreq_n         (mreq_n),
		.iorq_n         (iorq_n),
		.rd_n           (rd_n),
		.wr_n           (wr_n),
		.m1_n           (m1_n),
		.io_wr_pulse    (io_wr_pulse),
		.sel_7ffd       (sel_7ffd),
		.sel_7ffd_alias (sel_7ffd_alias),
		.sel_1ffd       (sel_1ffd),
		.sel_dffd       (sel_dffd),
		.sel_eff7       (sel_eff7),
		.sel_ula        (sel_ula),
		.mem_rd         (mem_rd),
		.mem_wr         (mem_wr)
	);

	spec_page_regs u_regs (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.machine        (mach_type),
		.data           (data),
		.io_wr_pulse    (io_wr_pulse),
		.sel_7ffd       (sel_7ffd),
		.sel_7ffd_alias (sel_7ffd_alias),
		.sel_1ffd       (sel_1ffd),
		.sel_dffd       (sel_dffd),
		.sel_eff7       (sel_eff7),
		.sel_ula        (sel_ula),
		.page_reg       (page_reg),
		.plus3_ctl      (plus3_ctl),
		.page_ext       (page_ext),
		.page_disable   (),              // Lock only gates writes inside u_regs
		.zx48           (zx48),
		.plus3          (plus3),
		.border_color   (border_color),
		.ear_out        (ear_out),
		.mic_out        (mic_out),
		.page_scr       (page_scr)
	);

	spec_ram_map u_map (
		.addr      (addr),
		.mem_rd    (mem_rd),
		.mem_wr    (mem_wr),
		.page_reg  (page_reg),
		.plus3_ctl (plus3_ctl),
		.page_ext  (page_ext),
		.zx48      (zx48),
		.plus3     (plus3),
		.ram_addr  (ram_addr),
		.ram_rd    (ram_rd),
		.ram_we    (ram_we)
	);

endmodule

//--- src/spec_page_regs.sv
module spec_page_regs (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  spec_pkg::machine_t    machine,
	input  logic [7:0]            data,
	input  logic                  io_wr_pulse,
	input  logic                  sel_7ffd,
	input  logic                  sel_7ffd_alias,
	input  logic                  sel_1ffd,
	input  logic                  sel_dffd,
	input  logic                  sel_eff7,
	input  logic                  sel_ula,
	output logic [7:0]            page_reg,
	output spec_pkg::plus3_ctl_u  plus3_ctl,
	output logic [2:0]            page_ext,
	output logic                  page_disable,
	output logic                  zx48,
	output logic                  plus3,
	output logic [2:0]            border_color,
	output logic                  ear_out,
	output logic                  mic_out,
	output logic                  page_scr
);

	import spec_pkg::*;

	logic p1024;
	logic pf1024;
	logic p1024_compat;     // EFF7 bit 2, plain 128K paging on Pentagon
	logic wr_7ffd;
	logic wr_1ffd;

	// ========================================
	// Paging lock
	// ========================================

	// Bit 5 of 7FFD locks paging until reset
	assign page_disable = zx48
		| (~p1024 & page_reg[5])
		| (p1024 & p1024_compat & page_reg[5]);

	// +3 decodes 7FFD fully, so the A14 low alias goes away
	assign wr_7ffd = sel_7ffd | (sel_7ffd_alias & ~plus3);
	assign wr_1ffd = sel_1ffd & plus3;

	assign page_scr = page_reg[3];    // Shadow screen in bank 7

	// ========================================
	// Paging registers and machine flags
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_reg     <= '0;
			plus3_ctl    <= '0;
			page_ext     <= '0;
			p1024_compat <= 1'b0;
			p1024        <= (machine == MACH_P1024);
			pf1024       <= (machine == MACH_PF1024);
			zx48         <= (machine == MACH_48);
			plus3        <= (machine == MACH_PLUS3);
		end else if (io_wr_pulse) begin
			if (!page_disable) begin
				if (wr_7ffd) begin
					page_reg <= data;
					// Pentagon spreads the extra bank bits over 7:5
					if (p1024 & ~p1024_compat) begin
						page_ext <= {data[5], data[7:6]};
					end
				end else if (wr_1ffd) begin
					plus3_ctl <= data;
				end
			end

			// Not affected by the lock
			if (pf1024 & sel_dffd) begin
				page_ext <= data[2:0];
			end
			if (p1024 & sel_eff7) begin
				p1024_compat <= data[2];
			end
		end
	end

	// ========================================
	// ULA port
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= '0;
			ear_out      <= 1'b0;
			mic_out      <= 1'b0;
		end else if (io_wr_pulse & sel_ula) begin
			border_color <= data[2:0];
			mic_out      <= data[3];
			ear_out      <= data[4];
		end
	end

endmodule

//--- src/spec_pkg.sv
`include "spec_cfg.svh"

package spec_pkg;

	// Machine type, sampled while reset is high
	typedef enum logic [2:0] {
		MACH_128    = `SPEC_MACH_128,
		MACH_P1024  = `SPEC_MACH_P1024,
		MACH_PF1024 = `SPEC_MACH_PF1024,
		MACH_48     = `SPEC_MACH_48,
		MACH_PLUS3  = `SPEC_MACH_PLUS3
	} machine_t;

	// Extension bits on top of the three 7FFD page bits
	typedef logic [5:0] ram_bank_t;

	// ========================================
	// Port 1FFD, +3 control
	// ========================================

	// Bit 0 picks which of the two views is live
	typedef union packed {
		struct packed {
			logic [3:0] unused_hi;
			logic       motor;      // Disk motor, no function here
			logic       rom_hi;     // High bit of the +3 ROM page
			logic       unused_lo;
			logic       special;
		} norm;
		struct packed {
			logic [4:0] unused;
			logic [1:0] mode_cfg;   // All-RAM layout select
			logic       special;
		} spec;
	} plus3_ctl_u;

endpackage

//--- src/spec_port_decode.sv
`include "spec_cfg.svh"

module spec_port_decode (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic [`SPEC_ADDR_W-1:0] addr,
	input  logic                    mreq_n,
	input  logic                    iorq_n,
	input  logic                    rd_n,
	input  logic                    wr_n,
	input  logic                    m1_n,
	output logic                    io_wr_pulse,
	output logic                    sel_7ffd,
	output logic                    sel_7ffd_alias,
	output logic                    sel_1ffd,
	output logic                    sel_dffd,
	output logic                    sel_eff7,
	output logic                    sel_ula,
	output logic                    mem_rd,
	output logic                    mem_wr
);

	logic io_wr;
	logic io_wr_prev;

	// ========================================
	// I/O write edge
	// ========================================

	// M1 low with IORQ low is an interrupt ack, not a write
	assign io_wr = ~iorq_n & ~wr_n & m1_n;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_prev <= 1'b0;
		end else begin
			io_wr_prev <= io_wr;
		end
	end

	assign io_wr_pulse = io_wr & ~io_wr_prev;    // First cycle only

	// ========================================
	// Port address patterns
	// ========================================

	// Partial decode, as on the real boards
	assign sel_7ffd       = ~addr[15] & addr[14] & ~addr[1];
	assign sel_7ffd_alias = ~addr[15] & ~addr[14] & ~addr[1];    // Older 128K decode
	assign sel_1ffd       = (addr[15:12] == 4'b0001) & ~addr[1];

	// Profi needs the full address
	assign sel_dffd = (addr == 16'hdffd);
	assign sel_eff7 = (addr[15:12] == 4'b1110) & ~addr[3];
	assign sel_ula  = ~addr[0];

	// Memory strobes as active-high levels
	assign mem_rd = ~mreq_n & ~rd_n;
	assign mem_wr = ~mreq_n & ~wr_n;

endmodule

//--- src/spec_ram_map.sv
`include "spec_cfg.svh"

module spec_ram_map (
	input  logic                    [`SPEC_ADDR_W-1:0] addr,
	input  logic                    mem_rd,
	input  logic                    mem_wr,
	input  logic [7:0]              page_reg,
	input  spec_pkg::plus3_ctl_u    plus3_ctl,
	input  logic [2:0]              page_ext,
	input  logic                    zx48,
	input  logic                    plus3,
	output logic [`SPEC_RAM_AW-1:0] ram_addr,
	output logic                    ram_rd,
	output logic                    ram_we
);

	import spec_pkg::*;

	logic       special;
	logic [1:0] mode_cfg;
	logic [3:0] rom_page;
	ram_bank_t  top_bank;
	logic [6:0] slot_page;    // Everything above the 16K offset

	assign special  = plus3_ctl.norm.special;
	assign mode_cfg = plus3_ctl.spec.mode_cfg;
	assign top_bank = {page_ext, page_reg[2:0]};

	// ========================================
	// ROM page select
	// ========================================

	always_comb begin
		if (plus3) begin
			rom_page = {2'b10, plus3_ctl.norm.rom_hi, page_reg[4]};
		end else begin
			// 48K is pinned to the last ROM page
			rom_page = {zx48, 2'b11, zx48 | page_reg[4]};
		end
	end

	// ========================================
	// Slot mapping
	// ========================================

	always_comb begin
		if (special) begin
			// +3 all-RAM layouts, four configs
			case (addr[15:14])
				2'b00:   slot_page = {4'b0000, |mode_cfg, 2'b00};
				2'b01:   slot_page = {4'b0000, |mode_cfg, &mode_cfg, 1'b1};
				2'b10:   slot_page = {4'b0000, |mode_cfg, 2'b10};
				default: slot_page = {4'b0000, mode_cfg == 2'b01, 2'b11};
			endcase
		end else begin
			case (addr[15:14])
				2'b00:   slot_page = {`SPEC_ROM_BASE, rom_page};
				2'b01:   slot_page = {4'b0000, `SPEC_BANK_SCREEN};
				2'b10:   slot_page = {4'b0000, `SPEC_BANK_MID};
				default: slot_page = {1'b0, top_bank};    // Switchable bank
			endcase
		end
	end

	assign ram_addr = `SPEC_RAM_AW'({slot_page, addr[13:0]});

	assign ram_rd = mem_rd;

	// ROM is read-only outside the all-RAM modes
	assign ram_we = mem_wr & (special | (|addr[15:14]));

endmodule

//--- tb/tb_spec_mem_pager.sv
`include "spec_cfg.svh"

module tb_spec_mem_pager;

	localparam int MAX_ENTRIES = 32;
	localparam int TIMEOUT_CYCLES = 8;

	logic        clk_sys;
	logic        reset;
	logic [2:0]  machine;
	logic [15:0] addr;
	logic [7:0]  data;
	logic        mreq_n;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic        m1_n;
	logic [24:0] ram_addr;
	logic        ram_rd;
	logic        ram_we;
	logic [2:0]  border_color;
	logic        ear_out;
	logic        mic_out;
	logic        page_scr;

	// ========================================
	// Stimulus table
	// ========================================

	logic [2:0]  t_mach    [MAX_ENTRIES];
	logic [1:0]  t_slot    [MAX_ENTRIES];    // Probe addr[15:14]
	logic [6:0]  t_page    [MAX_ENTRIES];    // Expected ram_addr[20:14]
	logic        t_we      [MAX_ENTRIES];
	logic [4:0]  t_ula     [MAX_ENTRIES];    // {ear, mic, border}
	logic        t_scr     [MAX_ENTRIES];
	int          t_nwr     [MAX_ENTRIES];
	logic [15:0] t_wr_addr [MAX_ENTRIES][3];
	logic [7:0]  t_wr_data [MAX_ENTRIES][3];
	int          n_entries;

	spec_mem_pager dut0 (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.machine      (machine),
		.addr         (addr),
		.data         (data),
		.mreq_n       (mreq_n),
		.iorq_n       (iorq_n),
		.rd_n         (rd_n),
		.wr_n         (wr_n),
		.m1_n         (m1_n),
		.ram_addr     (ram_addr),
		.ram_rd       (ram_rd),
		.ram_we       (ram_we),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out),
		.page_scr     (page_scr)
	);

	always #5 clk_sys = ~clk_sys;

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	task automatic abort_run(input string why);
		$display("Timeout: %s", why);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic new_entry(input logic [2:0] mach, input logic [1:0] slot,
		input logic [6:0] page, input logic we, input logic [4:0] ula, input logic scr);
		t_mach[n_entries] = mach;
		t_slot[n_entries] = slot;
		t_page[n_entries] = page;
		t_we[n_entries]   = we;
		t_ula[n_entries]  = ula;
		t_scr[n_entries]  = scr;
		t_nwr[n_entries]  = 0;
		n_entries++;
	endtask

	task automatic add_write(input logic [15:0] a, input logic [7:0] d);
		int idx;
		idx = n_entries - 1;
		t_wr_addr[idx][t_nwr[idx]] = a;
		t_wr_data[idx][t_nwr[idx]] = d;
		t_nwr[idx]++;
	endtask

	// Expected pages are {101, rom page} for ROM and {0, ext, bank} for RAM
	task automatic build_table;
		new_entry(`SPEC_MACH_128, 2'd0, 7'h56, 1'b0, 5'h00, 1'b0);    // ROM page 0110
		new_entry(`SPEC_MACH_128, 2'd1, 7'h05, 1'b1, 5'h00, 1'b0);
		new_entry(`SPEC_MACH_128, 2'd2, 7'h02, 1'b1, 5'h00, 1'b0);
		new_entry(`SPEC_MACH_128, 2'd3, 7'h00, 1'b1, 5'h00, 1'b0);
		new_entry(`SPEC_MACH_128, 2'd3, 7'h03, 1'b1, 5'h00, 1'b0);
		add_write(16'h7ffd, 8'h13);
		new_entry(`SPEC_MACH_128, 2'd0, 7'h57, 1'b0, 5'h00, 1'b0);
		add_write(16'h7ffd, 8'h13);
		// A lock followed by a write that must be ignored
		new_entry(`SPEC_MACH_128, 2'd3, 7'h01, 1'b1, 5'h00, 1'b0);
		add_write(16'h7ffd, 8'h21);
		add_write(16'h7ffd, 8'h06);
		new_entry(`SPEC_MACH_128, 2'd3, 7'h04, 1'b1, 5'h00, 1'b0);
		add_write(16'h3ffd, 8'h04);    // A14 low alias
		// +3 special config 2 gives banks 4, 5, 6, 3
		new_entry(`SPEC_MACH_PLUS3, 2'd0, 7'h04, 1'b1, 5'h00, 1'b0);
		add_write(16'h1ffd, 8'h05);
		new_entry(`SPEC_MACH_PLUS3, 2'd1, 7'h05, 1'b1, 5'h00, 1'b0);
		add_write(16'h1ffd, 8'h05);
		new_entry(`SPEC_MACH_PLUS3, 2'd2, 7'h06, 1'b1, 5'h00, 1'b0);
		add_write(16'h1ffd, 8'h05);
		new_entry(`SPEC_MACH_PLUS3, 2'd3, 7'h03, 1'b1, 5'h00, 1'b0);
		add_write(16'h1ffd, 8'h05);
		new_entry(`SPEC_MACH_PLUS3, 2'd0, 7'h58, 1'b0, 5'h00, 1'b0);    // Normal mode ROM
		new_entry(`SPEC_MACH_PLUS3, 2'd0, 7'h5b, 1'b0, 5'h00, 1'b0);
		add_write(16'h7ffd, 8'h10);
		add_write(16'h1ffd, 8'h04);    // rom_hi
		new_entry(`SPEC_MACH_PLUS3, 2'd3, 7'h00, 1'b1, 5'h00, 1'b0);
		add_write(16'h3ffd, 8'h07);    // No alias on +3
		// Pentagon 1024 extension from bits 5, 7, 6
		new_entry(`SPEC_MACH_P1024, 2'd3, 7'h3a, 1'b1, 5'h00, 1'b0);
		add_write(16'h7ffd, 8'he2);
		new_entry(`SPEC_MACH_P1024, 2'd3, 7'h14, 1'b1, 5'h00, 1'b0);
		add_write(16'h7ffd, 8'h84);    // Bit 7 lands in the middle
		new_entry(`SPEC_MACH_P1024, 2'd3, 7'h09, 1'b1, 5'h00, 1'b0);
		add_write(16'h7ffd, 8'h41);    // Bit 6 lands at the bottom
		new_entry(`SPEC_MACH_P1024, 2'd3, 7'h02, 1'b1, 5'h00, 1'b0);
		add_write(16'heff7, 8'h04);
		add_write(16'h7ffd, 8'he2);
		new_entry(`SPEC_MACH_PF1024, 2'd3, 7'h28, 1'b1, 5'h00, 1'b0);
		add_write(16'hdffd, 8'h05);
		new_entry(`SPEC_MACH_PF1024, 2'd3, 7'h33, 1'b1, 5'h00, 1'b0);
		add_write(16'h7ffd, 8'h03);
		add_write(16'hdffd, 8'h06);
		// ULA port and shadow screen
		new_entry(`SPEC_MACH_128, 2'd1, 7'h05, 1'b1, 5'h1f, 1'b0);
		add_write(16'h00fe, 8'h1f);
		new_entry(`SPEC_MACH_128, 2'd3, 7'h00, 1'b1, 5'h0b, 1'b1);
		add_write(16'h7ffd, 8'h08);
		add_write(16'h00fe, 8'h0b);
		new_entry(`SPEC_MACH_48, 2'd0, 7'h5f, 1'b0, 5'h00, 1'b0);
		new_entry(`SPEC_MACH_48, 2'd3, 7'h00, 1'b1, 5'h00, 1'b0);
		add_write(16'h7ffd, 8'h07);
		new_entry(`SPEC_MACH_48, 2'd0, 7'h5f, 1'b0, 5'h00, 1'b0);
		add_write(16'h7ffd, 8'h17);
	endtask

	// ========================================
	// Bus tasks
	// ========================================

	task automatic apply_reset(input logic [2:0] mach);
		@(negedge clk_sys);
		reset   = 1'b1;
		machine = mach;
		mreq_n  = 1'b1;
		iorq_n  = 1'b1;
		rd_n    = 1'b1;
		wr_n    = 1'b1;
		repeat (10) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		@(negedge clk_sys);
		addr   = a;
		data   = d;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		repeat (2) @(negedge clk_sys);
		iorq_n = 1'b1;
		wr_n   = 1'b1;
	endtask

	task automatic wait_ram_rd(input logic level);
		int waited;
		waited = 0;
		@(negedge clk_sys);
		while (ram_rd !== level && waited < TIMEOUT_CYCLES) begin
			@(negedge clk_sys);
			waited++;
		end
		if (ram_rd !== level) begin
			abort_run("ram_rd did not follow the memory read strobe");
		end
	endtask

	// Read then write at the same probe address
	task automatic probe_entry(input int i, input logic [13:0] low);
		logic [24:0] exp_addr;
		exp_addr = {4'h0, t_page[i], low};
		@(negedge clk_sys);
		addr   = {t_slot[i], low};
		mreq_n = 1'b0;
		rd_n   = 1'b0;
		wait_ram_rd(1'b1);
		check_value($sformatf("ram_addr (entry %0d)", i), ram_addr, exp_addr);
		check_value($sformatf("ram_we on read (entry %0d)", i), ram_we, 1'b0);
		rd_n = 1'b1;
		wr_n = 1'b0;
		wait_ram_rd(1'b0);
		check_value($sformatf("ram_addr on write (entry %0d)", i), ram_addr, exp_addr);
		check_value($sformatf("ram_we (entry %0d)", i), ram_we, t_we[i]);
		mreq_n = 1'b1;
		wr_n   = 1'b1;
		check_value($sformatf("border_color (entry %0d)", i), border_color, t_ula[i][2:0]);
		check_value($sformatf("mic_out (entry %0d)", i), mic_out, t_ula[i][3]);
		check_value($sformatf("ear_out (entry %0d)", i), ear_out, t_ula[i][4]);
		check_value($sformatf("page_scr (entry %0d)", i), page_scr, t_scr[i]);
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		logic [31:0] seed;
		logic [31:0] rnd;
		clk_sys   = 1'b0;
		reset     = 1'b1;
		machine   = `SPEC_MACH_128;
		addr      = '0;
		data      = '0;
		mreq_n    = 1'b1;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		m1_n      = 1'b1;
		n_entries = 0;
		seed      = 32'hf39e9800;
		rnd       = $urandom(seed);

		build_table();
		for (int i = 0; i < n_entries; i++) begin
			apply_reset(t_mach[i]);
			for (int k = 0; k < t_nwr[i]; k++) begin
				io_write(t_wr_addr[i][k], t_wr_data[i][k]);
			end
			rnd = $urandom();
			probe_entry(i, rnd[13:0]);    // Low bits pass through unchanged
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule
